/* regPkg.sv */
`default_nettype none

package regPkg;

    // one byte of the register file.
    typedef logic [7:0] regData;

    // register number, r0 to r15.
    typedef logic [3:0] regIndex;

    // even/odd register pair, high register in the upper byte.
    typedef logic [15:0] pairData;

    // number of byte registers in the file.
    localparam int NUM_REGS = 16;

endpackage

`default_nettype wire

/* isaPkg.sv */
`default_nettype none

package isaPkg;

    // one instruction as it arrives from upstream.
    typedef logic [15:0] instWord;

    // immediate field, signed for ADIW.
    typedef logic [7:0] immData;

    // codes 4'hA to 4'hF are left free and act as no-operation.
    typedef enum logic [3:0] {
        opLdi  = 4'h0,
        opMov  = 4'h1,
        opAdd  = 4'h2,
        opSub  = 4'h3,
        opAnd  = 4'h4,
        opOr   = 4'h5,
        opEor  = 4'h6,
        opAdiw = 4'h7,
        opMovw = 4'h8,
        opOut  = 4'h9
    } opcode;

    // field positions inside an instruction word.
    localparam int OP_HI  = 15;
    localparam int OP_LO  = 12;
    localparam int DST_HI = 11;
    localparam int DST_LO = 8;
    localparam int SRC_HI = 3;
    localparam int SRC_LO = 0;
    localparam int IMM_HI = 7;
    localparam int IMM_LO = 0;

    function automatic opcode getOpcode(input instWord word);
        return opcode'(word[OP_HI:OP_LO]);
    endfunction

    function automatic regPkg::regIndex getDst(input instWord word);
        return word[DST_HI:DST_LO];
    endfunction

    function automatic regPkg::regIndex getSrc(input instWord word);
        return word[SRC_HI:SRC_LO];
    endfunction

    function automatic immData getImm(input instWord word);
        return word[IMM_HI:IMM_LO];
    endfunction

endpackage

`default_nettype wire

/* instBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module instBuffer #(
    parameter int INST_DEPTH = 4
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            pushEn,
    input  isaPkg::instWord pushData,
    input  logic            popEn,
    output isaPkg::instWord popData,
    output logic            empty
);

    localparam int PTR_W = (INST_DEPTH > 1) ? $clog2(INST_DEPTH) : 1;
    localparam int CNT_W = $clog2(INST_DEPTH + 1);

    isaPkg::instWord entries [INST_DEPTH];

    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic             doPop;

    // upstream credits keep pushes within the free space.
    assign doPop = popEn && !empty;
    assign empty = (count == '0);
    assign popData = entries[rdPtr];

    always_ff @(posedge clk) begin
        if (pushEn) begin
            entries[wrPtr] <= pushData;
        end
    end

    // pointers wrap at the depth, which need not be a power of two.
    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushEn) begin
                wrPtr <= (wrPtr == PTR_W'(INST_DEPTH - 1)) ? '0 : wrPtr + PTR_W'(1);
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PTR_W'(INST_DEPTH - 1)) ? '0 : rdPtr + PTR_W'(1);
            end
            case ({pushEn, doPop})
                2'b10: count <= count + CNT_W'(1);
                2'b01: count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic            clk,
    input  logic            reset,
    input  regPkg::regIndex aSelect,
    input  regPkg::regIndex bSelect,
    input  logic            byteWrite,
    input  regPkg::regData  byteData,
    input  logic            pairAdd,
    input  logic            pairMove,
    input  isaPkg::immData  constant,
    output regPkg::regData  outA,
    output regPkg::regData  outB
);

    regPkg::regData regs [regPkg::NUM_REGS];

    // pair registers, the low bit of the select is dropped.
    regPkg::regIndex aLow;
    regPkg::regIndex aHigh;
    regPkg::regIndex bLow;
    regPkg::regIndex bHigh;

    regPkg::pairData aPair;
    regPkg::pairData bPair;
    regPkg::pairData pairSum;
    regPkg::pairData extConst;

    assign aLow  = {aSelect[3:1], 1'b0};
    assign aHigh = {aSelect[3:1], 1'b1};
    assign bLow  = {bSelect[3:1], 1'b0};
    assign bHigh = {bSelect[3:1], 1'b1};

    assign aPair = {regs[aHigh], regs[aLow]};
    assign bPair = {regs[bHigh], regs[bLow]};

    // sign-extend the immediate so a negative value borrows from the high byte.
    assign extConst = {{8{constant[7]}}, constant};

    // wraps modulo 65536.
    assign pairSum = aPair + extConst;

    // reads are combinational, so a write is seen by the next instruction.
    assign outA = regs[aSelect];
    assign outB = regs[bSelect];

    // only one write command is active per cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regPkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (byteWrite) begin
            regs[aSelect] <= byteData;
        end else if (pairAdd) begin
            regs[aLow]  <= pairSum[7:0];
            regs[aHigh] <= pairSum[15:8];
        end else if (pairMove) begin
            regs[aLow]  <= bPair[7:0];
            regs[aHigh] <= bPair[15:8];
        end
    end

endmodule

`default_nettype wire

/* aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  isaPkg::opcode  op,
    input  regPkg::regData opA,
    input  regPkg::regData opB,
    output regPkg::regData result
);

    // 8-bit results wrap modulo 256, no flags are kept.
    always_comb begin
        case (op)
            isaPkg::opAdd: begin
                result = opA + opB;
            end
            isaPkg::opSub: begin
                result = opA - opB;
            end
            isaPkg::opAnd: begin
                result = opA & opB;
            end
            isaPkg::opOr: begin
                result = opA | opB;
            end
            isaPkg::opEor: begin
                result = opA ^ opB;
            end
            // the immediate of LDI arrives on opB.
            isaPkg::opMov, isaPkg::opLdi: begin
                result = opB;
            end
            // pair ops and OUT do not use the ALU.
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* execControl.sv */
`timescale 1ns/1ps
`default_nettype none

module execControl #(
    parameter int RESULT_CREDITS = 2
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            bufEmpty,
    input  isaPkg::instWord bufData,
    input  regPkg::regData  regA,
    input  regPkg::regData  regB,
    input  regPkg::regData  aluResult,
    input  logic            resultCredit,
    output logic            popEn,
    output logic            instCredit,
    output regPkg::regIndex aSelect,
    output regPkg::regIndex bSelect,
    output logic            byteWrite,
    output regPkg::regData  byteData,
    output logic            pairAdd,
    output logic            pairMove,
    output isaPkg::immData  constant,
    output isaPkg::opcode   aluOp,
    output regPkg::regData  aluA,
    output regPkg::regData  aluB,
    output logic            resultValid,
    output regPkg::regData  resultData
);

    localparam int CNT_W = $clog2(RESULT_CREDITS + 1);

    typedef enum logic [1:0] {
        stFetch,
        stExec,
        stWaitCredit
    } ctrlState;

    ctrlState         state;
    isaPkg::instWord  instReg;
    isaPkg::opcode    curOp;
    isaPkg::immData   curImm;
    logic [CNT_W-1:0] creditCount;
    logic             haveCredit;
    logic             inExec;
    logic             isByteOp;
    logic             sendOut;

    // decode of the latched instruction.
    assign curOp  = isaPkg::getOpcode(instReg);
    assign curImm = isaPkg::getImm(instReg);
    assign inExec = (state == stExec);
    assign haveCredit = (creditCount != '0);

    // pop at the edge that leaves fetch.
    assign popEn = (state == stFetch) && !bufEmpty;

    assign aSelect  = isaPkg::getDst(instReg);
    assign bSelect  = isaPkg::getSrc(instReg);
    assign constant = curImm;

    assign aluOp = curOp;
    assign aluA  = regA;
    assign aluB  = (curOp == isaPkg::opLdi) ? curImm : regB;

    always_comb begin
        case (curOp)
            isaPkg::opLdi, isaPkg::opMov, isaPkg::opAdd, isaPkg::opSub,
            isaPkg::opAnd, isaPkg::opOr, isaPkg::opEor: begin
                isByteOp = 1'b1;
            end
            default: begin
                isByteOp = 1'b0;
            end
        endcase
    end

    // write steering, only during the execute cycle.
    assign byteWrite = inExec && isByteOp;
    assign byteData  = aluResult;
    assign pairAdd   = inExec && (curOp == isaPkg::opAdiw);
    assign pairMove  = inExec && (curOp == isaPkg::opMovw);

    // an OUT leaves as soon as a result credit is held.
    assign sendOut = haveCredit &&
                     ((inExec && (curOp == isaPkg::opOut)) || (state == stWaitCredit));

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= stFetch;
            instCredit  <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            instCredit  <= popEn;
            resultValid <= sendOut;
            case (state)
                stFetch: begin
                    if (!bufEmpty) begin
                        state <= stExec;
                    end
                end
                stExec: begin
                    if ((curOp == isaPkg::opOut) && !haveCredit) begin
                        state <= stWaitCredit;
                    end else begin
                        state <= stFetch;
                    end
                end
                stWaitCredit: begin
                    if (haveCredit) begin
                        state <= stFetch;
                    end
                end
                default: begin
                    state <= stFetch;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (popEn) begin
            instReg <= bufData;
        end
        if (sendOut) begin
            resultData <= regA;
        end
    end

    // one credit spent per result, one back per credit pulse.
    always_ff @(posedge clk) begin
        if (reset) begin
            creditCount <= CNT_W'(RESULT_CREDITS);
        end else begin
            case ({resultCredit, resultValid})
                2'b10: creditCount <= creditCount + CNT_W'(1);
                2'b01: creditCount <= creditCount - CNT_W'(1);
                default: creditCount <= creditCount;
            endcase
        end
    end

endmodule

`default_nettype wire

/* avrExecTop.sv */
`timescale 1ns/1ps
`default_nettype none

module avrExecTop #(
    parameter int INST_DEPTH     = 4,
    parameter int RESULT_CREDITS = 2
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            instValid,
    input  isaPkg::instWord instData,
    input  logic            resultCredit,
    output logic            instCredit,
    output logic            resultValid,
    output regPkg::regData  resultData
);

    logic            bufEmpty;
    isaPkg::instWord bufData;
    logic            popEn;
    regPkg::regIndex aSelect;
    regPkg::regIndex bSelect;
    logic            byteWrite;
    regPkg::regData  byteData;
    logic            pairAdd;
    logic            pairMove;
    isaPkg::immData  constant;
    isaPkg::opcode   aluOp;
    regPkg::regData  aluA;
    regPkg::regData  aluB;
    regPkg::regData  aluResult;
    regPkg::regData  regA;
    regPkg::regData  regB;

    instBuffer #(
        .INST_DEPTH(INST_DEPTH)
    ) instBuffer_inst (
        .clk     (clk),
        .reset   (reset),
        .pushEn  (instValid),
        .pushData(instData),
        .popEn   (popEn),
        .popData (bufData),
        .empty   (bufEmpty)
    );

    execControl #(
        .RESULT_CREDITS(RESULT_CREDITS)
    ) execControl_inst (
        .clk         (clk),
        .reset       (reset),
        .bufEmpty    (bufEmpty),
        .bufData     (bufData),
        .regA        (regA),
        .regB        (regB),
        .aluResult   (aluResult),
        .resultCredit(resultCredit),
        .popEn       (popEn),
        .instCredit  (instCredit),
        .aSelect     (aSelect),
        .bSelect     (bSelect),
        .byteWrite   (byteWrite),
        .byteData    (byteData),
        .pairAdd     (pairAdd),
        .pairMove    (pairMove),
        .constant    (constant),
        .aluOp       (aluOp),
        .aluA        (aluA),
        .aluB        (aluB),
        .resultValid (resultValid),
        .resultData  (resultData)
    );

    regFile regFile_inst (
        .clk      (clk),
        .reset    (reset),
        .aSelect  (aSelect),
        .bSelect  (bSelect),
        .byteWrite(byteWrite),
        .byteData (byteData),
        .pairAdd  (pairAdd),
        .pairMove (pairMove),
        .constant (constant),
        .outA     (regA),
        .outB     (regB)
    );

    aluUnit aluUnit_inst (
        .op    (aluOp),
        .opA   (aluA),
        .opB   (aluB),
        .result(aluResult)
    );

endmodule

`default_nettype wire

/* avrExec_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module avrExecAssertions #(
    parameter int RESULT_CREDITS = 2
) (
    input logic clk,
    input logic reset,
    input logic instValid,
    input logic instCredit,
    input logic resultValid,
    input logic resultCredit
);

    int acceptedCount = 0;
    int creditedCount = 0;
    int availCredits;
    int failCount = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            acceptedCount <= 0;
            creditedCount <= 0;
        end else begin
            if (instValid) begin
                acceptedCount <= acceptedCount + 1;
            end
            if (instCredit) begin
                creditedCount <= creditedCount + 1;
            end
        end
    end

    // result credits as downstream sees them.
    always_ff @(posedge clk) begin
        if (reset) begin
            availCredits <= RESULT_CREDITS;
        end else begin
            availCredits <= availCredits + int'(resultCredit) - int'(resultValid);
        end
    end

    // a result is launched from a cycle that still held a credit.
    resultNeedsCredit: assert property (@(posedge clk) disable iff (reset)
        resultValid |-> ($past(availCredits) > 0))
        else begin
            failCount++;
            $error("resultValid rose with the result credit counter at zero");
        end

    creditAfterAccept: assert property (@(posedge clk) disable iff (reset)
        instCredit |-> (creditedCount < acceptedCount))
        else begin
            failCount++;
            $error("instCredit returned more credits than instructions accepted");
        end

    quietAfterReset: assert property (@(posedge clk)
        $fell(reset) |-> (!instCredit && !resultValid))
        else begin
            failCount++;
            $error("instCredit or resultValid high in the cycle after reset");
        end

endmodule

bind avrExecTop avrExecAssertions #(
    .RESULT_CREDITS(RESULT_CREDITS)
) avrExecAssertions_inst (
    .clk         (clk),
    .reset       (reset),
    .instValid   (instValid),
    .instCredit  (instCredit),
    .resultValid (resultValid),
    .resultCredit(resultCredit)
);

`default_nettype wire

/* avrExecTb.sv */
`timescale 1ns/1ps
`default_nettype none

module avrExecTb;

    localparam int INST_DEPTH     = 4;
    localparam int RESULT_CREDITS = 2;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int HOLD_CYCLES    = 40;

    // one table row, an instruction and the OUT value it should produce.
    typedef struct {
        isaPkg::instWord word;
        bit              hasResult;
        regPkg::regData  expValue;
    } stepEntry;

    logic            clk;
    logic            reset;
    logic            instValid;
    isaPkg::instWord instData;
    logic            resultCredit;
    logic            instCredit;
    logic            resultValid;
    regPkg::regData  resultData;

    stepEntry       steps [$];
    regPkg::regData expQ [$];
    integer         seed = 36334;
    int             splitIndex = 0;
    int             phaseBase = 0;
    int             sentCount = 0;
    int             expectedTotal = 0;
    int             creditPulses = 0;
    int             resultsSeen = 0;
    int             creditsReturned = 0;
    int             creditDelay = 0;
    bit             holdCredits = 1'b0;

    avrExecTop #(
        .INST_DEPTH    (INST_DEPTH),
        .RESULT_CREDITS(RESULT_CREDITS)
    ) avrExecTop_inst (
        .clk         (clk),
        .reset       (reset),
        .instValid   (instValid),
        .instData    (instData),
        .resultCredit(resultCredit),
        .instCredit  (instCredit),
        .resultValid (resultValid),
        .resultData  (resultData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic reportFailure(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic checkResult(input regPkg::regData actual, input regPkg::regData expected,
                               input string name);
        if (actual !== expected) begin
            reportFailure($sformatf("Mismatch %s: got 0x%02h, expected 0x%02h",
                                    name, actual, expected));
        end
    endtask

    task automatic checkCount(input int actual, input int expected, input string name);
        if (actual != expected) begin
            reportFailure($sformatf("Mismatch %s: got 0x%0h, expected 0x%0h",
                                    name, actual, expected));
        end
    endtask

    function automatic isaPkg::instWord makeInst(input isaPkg::opcode op,
                                                 input regPkg::regIndex dst,
                                                 input logic [7:0] low);
        return {op, dst, low};
    endfunction

    task automatic addStep(input isaPkg::instWord word, input bit hasResult,
                           input regPkg::regData expValue);
        stepEntry entry;
        entry.word      = word;
        entry.hasResult = hasResult;
        entry.expValue  = expValue;
        steps.push_back(entry);
    endtask

    task automatic addOut(input regPkg::regIndex r, input regPkg::regData expValue);
        addStep(makeInst(isaPkg::opOut, r, 8'h00), 1'b1, expValue);
    endtask

    task automatic buildTable();
        // every register reads zero after reset.
        for (int r = 0; r < regPkg::NUM_REGS; r++) begin
            addOut(regPkg::regIndex'(r), 8'h00);
        end
        addStep(makeInst(isaPkg::opLdi, 4'd1, 8'h7F), 1'b0, 8'h00);
        addOut(4'd1, 8'h7F);
        addStep(makeInst(isaPkg::opLdi, 4'd2, 8'h95), 1'b0, 8'h00);
        // 0x7F + 0x95 wraps to 0x14.
        addStep(makeInst(isaPkg::opAdd, 4'd1, 8'h02), 1'b0, 8'h00);
        addOut(4'd1, 8'h14);
        addStep(makeInst(isaPkg::opLdi, 4'd3, 8'h20), 1'b0, 8'h00);
        addStep(makeInst(isaPkg::opSub, 4'd3, 8'h02), 1'b0, 8'h00);
        addOut(4'd3, 8'h8B);
        addStep(makeInst(isaPkg::opLdi, 4'd4, 8'hF0), 1'b0, 8'h00);
        addStep(makeInst(isaPkg::opAnd, 4'd4, 8'h02), 1'b0, 8'h00);
        addOut(4'd4, 8'h90);
        addStep(makeInst(isaPkg::opLdi, 4'd5, 8'h0C), 1'b0, 8'h00);
        addStep(makeInst(isaPkg::opOr, 4'd5, 8'h02), 1'b0, 8'h00);
        addOut(4'd5, 8'h9D);
        addStep(makeInst(isaPkg::opLdi, 4'd6, 8'hFF), 1'b0, 8'h00);
        addStep(makeInst(isaPkg::opEor, 4'd6, 8'h02), 1'b0, 8'h00);
        addOut(4'd6, 8'h6A);
        addStep(makeInst(isaPkg::opMov, 4'd7, 8'h03), 1'b0, 8'h00);
        addOut(4'd7, 8'h8B);
        // pair r9:r8 = 0x12F0, +0x20 carries into the high byte.
        addStep(makeInst(isaPkg::opLdi, 4'd8, 8'hF0), 1'b0, 8'h00);
        addStep(makeInst(isaPkg::opLdi, 4'd9, 8'h12), 1'b0, 8'h00);
        addStep(makeInst(isaPkg::opAdiw, 4'd8, 8'h20), 1'b0, 8'h00);
        addOut(4'd8, 8'h10);
        addOut(4'd9, 8'h13);
        // -32 through the odd index borrows back to 0x12F0.
        addStep(makeInst(isaPkg::opAdiw, 4'd9, 8'hE0), 1'b0, 8'h00);
        addOut(4'd8, 8'hF0);
        addOut(4'd9, 8'h12);
        addStep(makeInst(isaPkg::opLdi, 4'd10, 8'hFF), 1'b0, 8'h00);
        addStep(makeInst(isaPkg::opLdi, 4'd11, 8'hFF), 1'b0, 8'h00);
        addStep(makeInst(isaPkg::opAdiw, 4'd10, 8'h01), 1'b0, 8'h00);
        addOut(4'd10, 8'h00);
        addOut(4'd11, 8'h00);
        addStep(makeInst(isaPkg::opMovw, 4'd12, 8'h08), 1'b0, 8'h00);
        addOut(4'd12, 8'hF0);
        addOut(4'd13, 8'h12);
        addStep(makeInst(isaPkg::opMovw, 4'd15, 8'h09), 1'b0, 8'h00);
        addOut(4'd14, 8'hF0);
        addOut(4'd15, 8'h12);
        // unused opcode 0xA leaves r1 alone.
        addStep(16'hA1FF, 1'b0, 8'h00);
        addOut(4'd1, 8'h14);
        splitIndex = steps.size();
        // more OUTs than result credits, sent while credits are held back.
        addOut(4'd1, 8'h14);
        addOut(4'd3, 8'h8B);
        addOut(4'd4, 8'h90);
        addOut(4'd5, 8'h9D);
        addOut(4'd6, 8'h6A);
    endtask

    // starts and ends on a falling edge.
    task automatic applyEntries(input int first, input int last);
        int waitCycles;
        for (int idx = first; idx < last; idx++) begin
            waitCycles = 0;
            while (INST_DEPTH + creditPulses - sentCount <= 0) begin
                instValid = 1'b0;
                @(negedge clk);
                waitCycles++;
                if (waitCycles > TIMEOUT_CYCLES) begin
                    reportFailure("timeout waiting for an instruction credit");
                end
            end
            instValid = 1'b1;
            instData  = steps[idx].word;
            sentCount++;
            if (steps[idx].hasResult) begin
                expQ.push_back(steps[idx].expValue);
                expectedTotal++;
            end
            @(negedge clk);
        end
        instValid = 1'b0;
    endtask

    task automatic waitIdle();
        int waitCycles;
        waitCycles = 0;
        while (resultsSeen < expectedTotal || creditsReturned < resultsSeen) begin
            @(negedge clk);
            waitCycles++;
            if (waitCycles > TIMEOUT_CYCLES) begin
                reportFailure("timeout waiting for all results and result credits");
            end
        end
    endtask

    task automatic setCreditHold(input bit value);
        @(posedge clk);
        holdCredits = value;
        @(negedge clk);
    endtask

    // sampled before the edge updates them.
    always @(posedge clk) begin
        if (!reset && instCredit) begin
            creditPulses <= creditPulses + 1;
        end
        if (!reset && resultValid) begin
            if (resultsSeen - creditsReturned >= RESULT_CREDITS) begin
                reportFailure("a result was sent without a result credit");
            end
            if (expQ.size() == 0) begin
                reportFailure("a result arrived with no OUT outstanding");
            end else begin
                checkResult(resultData, expQ.pop_front(), "resultData");
            end
            resultsSeen <= resultsSeen + 1;
        end
    end

    // each result earns one credit back after a random delay.
    always @(negedge clk) begin
        resultCredit = 1'b0;
        if (!holdCredits && (resultsSeen - creditsReturned > 0)) begin
            if (creditDelay == 0) begin
                resultCredit = 1'b1;
                creditsReturned <= creditsReturned + 1;
                creditDelay = $unsigned($random(seed)) % 4;
            end else begin
                creditDelay--;
            end
        end
    end

    always @(negedge clk) begin
        if (avrExecTop_inst.avrExecAssertions_inst.failCount != 0) begin
            reportFailure("a bound assertion on the credit rules failed");
        end
    end

    initial begin
        reset        = 1'b1;
        instValid    = 1'b0;
        instData     = '0;
        resultCredit = 1'b0;
        buildTable();
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (5) begin
            @(negedge clk);
            if (instCredit || resultValid) begin
                reportFailure("instCredit or resultValid pulsed before any instruction");
            end
        end
        applyEntries(0, splitIndex);
        waitIdle();
        setCreditHold(1'b1);
        phaseBase = resultsSeen;
        applyEntries(splitIndex, steps.size());
        repeat (HOLD_CYCLES) @(negedge clk);
        checkCount(resultsSeen - phaseBase, RESULT_CREDITS, "results while credits held");
        setCreditHold(1'b0);
        waitIdle();
        checkCount(creditPulses, sentCount, "instCredit pulses");
        checkCount(expQ.size(), 0, "outstanding results");
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
regPkg.sv
isaPkg.sv
instBuffer.sv
regFile.sv
aluUnit.sv
execControl.sv
avrExecTop.sv
avrExec_assertions.sv
avrExecTb.sv

/* Bender.yml */
package:
  name: avr_exec

sources:
  - regPkg.sv
  - isaPkg.sv
  - instBuffer.sv
  - regFile.sv
  - aluUnit.sv
  - execControl.sv
  - avrExecTop.sv
  - target: test
    files:
      - avrExec_assertions.sv
      - avrExecTb.sv
